// ==== Bender.yml ====
package:
  name: addr_controller

sources:
  - target: any(synthesis, simulation)
    files:
      - logic/macBusPkg.sv
      - logic/addrDecoder.sv
      - logic/busSlotSequencer.sv
      - logic/videoTimer.sv
      - logic/soundAddrGen.sv
      - logic/memAddrMapper.sv
      - logic/addrController.sv
  - target: simulation
    files:
      - sim/addrController_props.sv
      - sim/addrControllerTb.sv

// ==== logic/addrController.sv ====
`timescale 1ns/1ps

module addrController import macBusPkg::*; #(
	parameter int lineClocks   = 352,
	parameter int activeClocks = 128,
	parameter int hsyncClocks  = 32,
	parameter int frameLines   = 370,
	parameter int activeLines  = 342,
	parameter int vsyncLines   = 4,
	parameter int frameEvents  = 135408,
	parameter int stepEvents   = 5920
) (
	input  logic      clk8,
	input  logic      arstN,
	input  memConfigT memConfig,
	input  cpuAddrT   cpuAddr,		// 68000 strobe interface
	input  logic      cpuUdsN,
	input  logic      cpuLdsN,
	input  logic      cpuRw,
	input  logic      memoryOverlayOn,
	input  logic      sndAlt,
	input  memAddrT   dskReadAddrInt,	// held valid, taken on dskIntAck
	input  memAddrT   dskReadAddrExt,
	output memAddrT   memoryAddr,
	output logic      memoryUdsN,
	output logic      memoryLdsN,
	output logic      romOeN,
	output logic      ramOeN,
	output logic      ramWeN,
	output busSlotT   busSlot,
	output logic      scsiSel,
	output logic      sccSel,
	output logic      iwmSel,
	output logic      viaSel,
	output logic      hsync,
	output logic      vsync,
	output logic      hblankN,
	output logic      vblankN,
	output logic      loadPixels,
	output logic      loadSound
);

	selectT  select;
	memAddrT videoAddr;
	memAddrT sndAddr;

	assign loadSound = busSlot.sndAck;	// sample word is on the bus now

	addrDecoder u_addrDecoder (
		.address(cpuAddr), .memoryOverlayOn(memoryOverlayOn), .select(select),
		.scsiSel(scsiSel), .sccSel(sccSel), .iwmSel(iwmSel), .viaSel(viaSel)
	);

	busSlotSequencer u_busSlotSequencer (
		.clk8(clk8), .arstN(arstN), .turbo(memConfig.turbo), .busSlot(busSlot)
	);

	videoTimer #(
		.lineClocks(lineClocks), .activeClocks(activeClocks), .hsyncClocks(hsyncClocks),
		.frameLines(frameLines), .activeLines(activeLines), .vsyncLines(vsyncLines)
	) u_videoTimer (
		.clk8(clk8), .arstN(arstN), .busSlot(busSlot), .videoAddr(videoAddr),
		.hsync(hsync), .vsync(vsync), .hblankN(hblankN), .vblankN(vblankN),
		.loadPixels(loadPixels)
	);

	soundAddrGen #(.frameEvents(frameEvents), .stepEvents(stepEvents)) u_soundAddrGen (
		.clk8(clk8), .arstN(arstN), .sndAck(busSlot.sndAck), .vblankN(vblankN),
		.sndAlt(sndAlt), .sndAddr(sndAddr)
	);

	memAddrMapper u_memAddrMapper (
		.memConfig(memConfig), .busSlot(busSlot), .select(select), .cpuAddr(cpuAddr),
		.cpuUdsN(cpuUdsN), .cpuLdsN(cpuLdsN), .cpuRw(cpuRw), .videoAddr(videoAddr),
		.sndAddr(sndAddr), .dskReadAddrInt(dskReadAddrInt), .dskReadAddrExt(dskReadAddrExt),
		.hblankN(hblankN), .memoryAddr(memoryAddr), .memoryUdsN(memoryUdsN),
		.memoryLdsN(memoryLdsN), .romOeN(romOeN), .ramOeN(ramOeN), .ramWeN(ramWeN)
	);

endmodule

// ==== logic/addrDecoder.sv ====
`timescale 1ns/1ps

module addrDecoder import macBusPkg::*; (
	input  cpuAddrT address,
	input  logic    memoryOverlayOn,	// boot overlay maps rom at 0
	output selectT  select,
	output logic    scsiSel,
	output logic    sccSel,
	output logic    iwmSel,
	output logic    viaSel
);

	logic romLow;	// rom window at 0x000000 during boot
	logic romHigh;	// rom's normal home at 0x400000
	logic ramLow;	// ram at 0x000000 after boot
	logic ramHigh;	// ram moved up to 0x600000 while overlay is on

	assign romLow  = address[23:20] == 4'h0;
	assign romHigh = address[23:20] == 4'h4;
	assign ramLow  = address[23:22] == 2'b00;
	assign ramHigh = address[23:21] == 3'b011;

	always_comb begin
		select = '0;
		if (memoryOverlayOn) begin
			select.rom = romLow || romHigh;
			select.ram = ramHigh;
		end else begin
			select.rom = romHigh;
			select.ram = ramLow;
		end
		select.scsi = address[23:19] == 5'b0_1011;	// 0x580000 - 0x5fffff
		select.scc  = address[23:22] == 2'b10;		// 0x800000 - 0xbfffff
		select.iwm  = address[23:21] == 3'b110;		// 0xc00000 - 0xdfffff
		select.via  = address[23:19] == 5'b1_1101;	// 0xe80000 - 0xefffff
	end

	// peripheral chip selects go straight to the pins
	assign scsiSel = select.scsi;
	assign sccSel  = select.scc;
	assign iwmSel  = select.iwm;
	assign viaSel  = select.via;

endmodule

// ==== logic/busSlotSequencer.sv ====
`timescale 1ns/1ps

module busSlotSequencer import macBusPkg::*; (
	input  logic    clk8,
	input  logic    arstN,
	input  logic    turbo,	// cpu also takes bus cycle 3
	output busSlotT busSlot
);

	logic [1:0] busCycle;	// position in the four clock bus cycle
	logic [1:0] slotCnt;	// which user gets the extra slot
	logic [1:0] subCycle;	// throttles the cpu to 3 of 4 bus cycles
	logic       extraSlot;
	logic       cpuNormal;
	logic       cpuFast;

	always_ff @(posedge clk8 or negedge arstN) begin
		if (!arstN) begin
			busCycle <= '0;
			slotCnt  <= '0;
			subCycle <= '0;
		end else begin
			busCycle <= busCycle + 2'd1;
			// both slow counters step as the bus cycle wraps
			if (busCycle == CYCLE_TURBO) begin
				slotCnt  <= slotCnt + 2'd1;
				subCycle <= subCycle + 2'd1;
			end
		end
	end

	assign extraSlot = busCycle == CYCLE_EXTRA;
	assign cpuNormal = (busCycle == CYCLE_CPU) && (subCycle != 2'd2);	// skip every fourth
	assign cpuFast   = (busCycle == CYCLE_CPU) || (busCycle == CYCLE_TURBO);

	always_comb begin
		busSlot            = '0;
		busSlot.videoGrant = busCycle == CYCLE_VIDEO;
		busSlot.cpuGrant   = turbo ? cpuFast : cpuNormal;
		busSlot.extraGrant = extraSlot;
		// floppies take extra slots 0 and 1, sound takes 2, slot 3 idles
		busSlot.dskIntAck  = extraSlot && (slotCnt == 2'd0);
		busSlot.dskExtAck  = extraSlot && (slotCnt == 2'd1);
		busSlot.sndAck     = extraSlot && (slotCnt == 2'd2);
	end

endmodule

// ==== logic/macBusPkg.sv ====
package macBusPkg;

	// address widths
	typedef logic [23:0] cpuAddrT;	// 68000 byte address
	typedef logic [21:0] memAddrT;	// 4 MB memory byte address
	typedef logic [1:0]  ramSizeT;	// 0 = 128K, 1 = 512K, 2 = 1M, 3 = 4M
	typedef logic [19:0] sndDivT;	// fractional sound step accumulator

	// machine configuration
	typedef struct packed {
		logic    turbo;		// cpu gets two slots per bus cycle
		logic    romSize;	// 0 = 64K, 1 = 128K
		ramSizeT ramSize;
	} memConfigT;

	// one-hot decode of a cpu address
	typedef struct packed {
		logic ram;
		logic rom;
		logic scsi;
		logic scc;
		logic iwm;
		logic via;
	} selectT;

	// who owns the memory bus in the current clock
	typedef struct packed {
		logic videoGrant;	// bus cycle 0
		logic cpuGrant;		// bus cycle 1, and 3 in turbo
		logic extraGrant;	// bus cycle 2, shared by disk and sound
		logic dskIntAck;	// internal floppy reader owns the extra slot
		logic dskExtAck;	// external floppy reader
		logic sndAck;		// sound fetch, doubles as loadSound
	} busSlotT;

	// disk images live in the upper part of the rom area
	localparam memAddrT DSK_INT_BASE = 22'h100000;	// first image at 1 MB
	localparam memAddrT DSK_EXT_BASE = 22'h200000;	// second image at 2 MB

	// sound buffers near the top of ram
	localparam memAddrT SND_MAIN_BASE = 22'h3FFD00;
	localparam memAddrT SND_ALT_BASE  = 22'h3FA100;

	// main screen buffer
	localparam memAddrT VID_BASE = 22'h3FA700;

	// bus cycle positions
	localparam logic [1:0] CYCLE_VIDEO = 2'd0;
	localparam logic [1:0] CYCLE_CPU   = 2'd1;
	localparam logic [1:0] CYCLE_EXTRA = 2'd2;
	localparam logic [1:0] CYCLE_TURBO = 2'd3;	// second cpu slot in turbo mode

endpackage

// ==== logic/memAddrMapper.sv ====
`timescale 1ns/1ps

module memAddrMapper import macBusPkg::*; (
	input  memConfigT memConfig,
	input  busSlotT   busSlot,
	input  selectT    select,
	input  cpuAddrT   cpuAddr,
	input  logic      cpuUdsN,
	input  logic      cpuLdsN,
	input  logic      cpuRw,		// high for a read
	input  memAddrT   videoAddr,
	input  memAddrT   sndAddr,
	input  memAddrT   dskReadAddrInt,
	input  memAddrT   dskReadAddrExt,
	input  logic      hblankN,		// video reads only in the visible part
	output memAddrT   memoryAddr,
	output logic      memoryUdsN,
	output logic      memoryLdsN,
	output logic      romOeN,
	output logic      ramOeN,
	output logic      ramWeN
);

	logic    cpuRam;
	logic    cpuRom;
	logic    ramAccess;
	logic    romAccess;
	logic    dskRead;
	memAddrT addrMux;
	memAddrT foldAddr;

	assign cpuRam    = busSlot.cpuGrant && select.ram;
	assign cpuRom    = busSlot.cpuGrant && select.rom;
	assign ramAccess = cpuRam || busSlot.videoGrant || busSlot.sndAck;	// video and sound are ram
	assign romAccess = cpuRom;
	assign dskRead   = busSlot.dskIntAck || busSlot.dskExtAck;	// disk images sit in rom space

	assign addrMux = busSlot.sndAck     ? sndAddr :
	                 busSlot.videoGrant ? videoAddr :
	                 cpuAddr[21:0];

	// fold the address down to the configured ram and rom sizes
	always_comb begin
		foldAddr = addrMux;
		if (ramAccess) begin
			if (memConfig.ramSize == 2'd0)
				foldAddr[18:17] = 2'b00;	// 128K
			if (!memConfig.ramSize[1])
				foldAddr[19] = 1'b0;		// 128K and 512K
			if (memConfig.ramSize != 2'd3)
				foldAddr[21:20] = 2'b00;	// everything below 4M
		end else if (romAccess) begin
			foldAddr[21:18] = 4'h0;
			if (!memConfig.romSize) begin
				foldAddr[16] = 1'b0;
				foldAddr[17] = 1'b1;		// 64K image is at 0x20000
			end else begin
				foldAddr[17] = 1'b0;
			end
		end
	end

	// disk reads bypass folding and land in their image area
	assign memoryAddr = busSlot.dskIntAck ? dskReadAddrInt + DSK_INT_BASE :
	                    busSlot.dskExtAck ? dskReadAddrExt + DSK_EXT_BASE :
	                    foldAddr;

	assign romOeN = !(dskRead || (cpuRom && cpuRw));
	assign ramOeN = !((busSlot.videoGrant && hblankN) || busSlot.sndAck || (cpuRam && cpuRw));
	assign ramWeN = !(cpuRam && !cpuRw);

	// other users always read whole words
	assign memoryUdsN = busSlot.cpuGrant ? cpuUdsN : 1'b0;
	assign memoryLdsN = busSlot.cpuGrant ? cpuLdsN : 1'b0;

endmodule

// ==== logic/soundAddrGen.sv ====
`timescale 1ns/1ps

module soundAddrGen import macBusPkg::*; #(
	parameter int frameEvents = 135408,	// clk8 events per frame, scaled
	parameter int stepEvents  = 5920	// events per sample step
) (
	input  logic    clk8,
	input  logic    arstN,
	input  logic    sndAck,		// sound owns this extra slot
	input  logic    vblankN,
	input  logic    sndAlt,		// alternate sound buffer
	output memAddrT sndAddr
);

	localparam sndDivT frameSize = sndDivT'(frameEvents);
	localparam sndDivT stepSize  = sndDivT'(stepEvents);

	sndDivT sndDiv;
	logic   vblankLast;	// vblankN as seen at the previous sound slot
	logic   frameStart;

	// vblankN fell since the last sound slot
	assign frameStart = vblankLast && !vblankN;

	always_ff @(posedge clk8 or negedge arstN) begin
		if (!arstN) begin
			sndAddr    <= SND_MAIN_BASE;
			sndDiv     <= '0;
			vblankLast <= 1'b0;
		end else if (sndAck) begin
			vblankLast <= vblankN;
			if (frameStart) begin
				sndAddr <= sndAlt ? SND_ALT_BASE : SND_MAIN_BASE;
				sndDiv  <= '0;
			end else if (sndDiv >= frameSize - 1'b1) begin
				sndDiv  <= sndDiv - frameSize + stepSize;	// keep the remainder
				sndAddr <= sndAddr + 22'd2;			// next sample word
			end else begin
				sndDiv <= sndDiv + stepSize;
			end
		end
	end

endmodule

// ==== logic/videoTimer.sv ====
`timescale 1ns/1ps

module videoTimer import macBusPkg::*; #(
	parameter int lineClocks   = 352,	// clk8 per line
	parameter int activeClocks = 128,	// visible part of a line
	parameter int hsyncClocks  = 32,
	parameter int frameLines   = 370,
	parameter int activeLines  = 342,
	parameter int vsyncLines   = 4
) (
	input  logic    clk8,
	input  logic    arstN,
	input  busSlotT busSlot,
	output memAddrT videoAddr,
	output logic    hsync,
	output logic    vsync,
	output logic    hblankN,
	output logic    vblankN,
	output logic    loadPixels	// frame buffer word on the bus last clock
);

	localparam int xBits = $clog2(lineClocks);
	localparam int yBits = $clog2(frameLines);

	logic [xBits-1:0] xPos;
	logic [xBits-1:0] xNext;
	logic [yBits-1:0] yPos;
	logic [yBits-1:0] yNext;
	logic             frameEnd;	// last clock of the last line
	logic             visible;

	assign frameEnd = (xPos == xBits'(lineClocks - 1)) && (yPos == yBits'(frameLines - 1));
	assign visible  = (xPos < xBits'(activeClocks)) && (yPos < yBits'(activeLines));

	always_comb begin
		xNext = xPos + 1'b1;
		yNext = yPos;
		if (xPos == xBits'(lineClocks - 1)) begin
			xNext = '0;
			yNext = (yPos == yBits'(frameLines - 1)) ? '0 : yPos + 1'b1;
		end
	end

	// beam position, and syncs taken from the next position so they line up with it
	always_ff @(posedge clk8 or negedge arstN) begin
		if (!arstN) begin
			xPos    <= '0;
			yPos    <= '0;
			hsync   <= 1'b0;
			vsync   <= 1'b0;
			hblankN <= 1'b0;
			vblankN <= 1'b0;
		end else begin
			xPos    <= xNext;
			yPos    <= yNext;
			hblankN <= xNext < xBits'(activeClocks);
			vblankN <= yNext < yBits'(activeLines);
			hsync   <= xNext >= xBits'(lineClocks - hsyncClocks);	// tail of the line
			vsync   <= yNext >= yBits'(frameLines - vsyncLines);
		end
	end

	// fetch address walks the frame buffer one word per visible video slot
	always_ff @(posedge clk8 or negedge arstN) begin
		if (!arstN) begin
			loadPixels <= 1'b0;
			videoAddr  <= VID_BASE;
		end else begin
			loadPixels <= busSlot.videoGrant && visible;
			if (frameEnd)
				videoAddr <= VID_BASE;	// ready for line 0
			else if (loadPixels)
				videoAddr <= videoAddr + 22'd2;
		end
	end

endmodule

// ==== sim/addrControllerTb.sv ====
`timescale 1ns/1ps

module addrControllerTb import macBusPkg::*; ();

	// shrunk video and sound timing so frames pass quickly
	localparam int lineClocks   = 32;
	localparam int activeClocks = 16;
	localparam int hsyncClocks  = 4;
	localparam int frameLines   = 8;
	localparam int activeLines  = 5;
	localparam int vsyncLines   = 2;
	localparam int frameEvents  = 100;
	localparam int stepEvents   = 30;
	localparam int rowCount     = 12;
	localparam int rowClocks    = 48;	// three rounds of the extra slot per row
	localparam int limitClocks  = rowCount * 64 + 4 * lineClocks * frameLines;

	typedef struct packed {
		memConfigT cfg;
		logic      overlay;
		logic      alt;		// sound buffer select
		cpuAddrT   addr;
		logic      udsN;
		logic      ldsN;
		logic      rw;
		memAddrT   dskInt;
		memAddrT   dskExt;
	} rowT;

	logic      clk8;
	logic      arstN;
	memConfigT memConfig;
	cpuAddrT   cpuAddr;
	logic      cpuUdsN, cpuLdsN, cpuRw;
	logic      memoryOverlayOn, sndAlt;
	memAddrT   dskReadAddrInt, dskReadAddrExt, memoryAddr;
	logic      memoryUdsN, memoryLdsN, romOeN, ramOeN, ramWeN;
	busSlotT   busSlot;
	logic      scsiSel, sccSel, iwmSel, viaSel;
	logic      hsync, vsync, hblankN, vblankN, loadPixels, loadSound;

	int      n;		// rising edges since reset release
	int      errors;
	int      failedTests;
	int      grantCount;
	rowT     rows [rowCount];
	memAddrT sndRef;	// sound model, follows the step rule
	int      accRef;
	logic    vbLastRef;
	memAddrT vidRef;	// frame buffer fetch model
	logic    pixRef;	// loadPixels expected in the current clock

	addrController #(
		.lineClocks(lineClocks), .activeClocks(activeClocks), .hsyncClocks(hsyncClocks),
		.frameLines(frameLines), .activeLines(activeLines), .vsyncLines(vsyncLines),
		.frameEvents(frameEvents), .stepEvents(stepEvents)
	) u_addrController (.*);

	initial begin
		clk8 = 1'b0;
		forever #5 clk8 = ~clk8;
	end

	always @(posedge clk8 or negedge arstN) begin
		if (!arstN)
			n <= 0;
		else
			n <= n + 1;
	end

	initial begin
		#(limitClocks * 10);
		$display("timeout: run did not finish within %0d clocks", limitClocks);
		$display("=== FAIL ===");
		$finish;
	end

	function automatic memAddrT ramFold(memAddrT a, ramSizeT size);
		memAddrT f;
		f = a;
		if (size == 2'd0)
			f = f & ~22'h060000;	// 128K mirrors every 128K
		if (size < 2'd2)
			f = f & ~22'h080000;
		if (size < 2'd3)
			f = f & ~22'h300000;
		return f;
	endfunction

	function automatic memAddrT romFold(memAddrT a, logic romSize);
		memAddrT f;
		f = a & 22'h03FFFF;	// rom never sees more than 256K
		if (romSize)
			f = f & ~22'h020000;
		else
			f = (f & ~22'h010000) | 22'h020000;	// 64K image sits at 0x20000
		return f;
	endfunction

	function automatic selectT decodeRef(cpuAddrT a, logic ov);
		selectT s;
		s = '0;
		if (ov) begin
			s.rom = a < 24'h100000 || (a >= 24'h400000 && a < 24'h500000);
			s.ram = a >= 24'h600000 && a < 24'h800000;
		end else begin
			s.ram = a < 24'h400000;
			s.rom = a >= 24'h400000 && a < 24'h500000;
		end
		s.scsi = a >= 24'h580000 && a < 24'h600000;
		s.scc  = a >= 24'h800000 && a < 24'hC00000;
		s.iwm  = a >= 24'hC00000 && a < 24'hE00000;
		s.via  = a >= 24'hE80000 && a < 24'hF00000;
		return s;
	endfunction

	// expected owner of the bus after cnt edges
	function automatic busSlotT slotRef(int cnt, logic turbo);
		busSlotT s;
		int      bc;
		int      sub;
		bc = cnt % 4;
		sub = (cnt / 4) % 4;
		s = '0;
		s.videoGrant = bc == 0;
		s.cpuGrant   = turbo ? (bc == 1 || bc == 3) : (bc == 1 && sub != 2);
		s.extraGrant = bc == 2;
		s.dskIntAck  = bc == 2 && sub == 0;
		s.dskExtAck  = bc == 2 && sub == 1;
		s.sndAck     = bc == 2 && sub == 2;
		return s;
	endfunction

	function automatic logic vblankRef(int cnt);
		return cnt > 0 && (cnt / lineClocks) % frameLines < activeLines;
	endfunction

	function automatic rowT makeRow(logic turbo, logic romSize, ramSizeT ramSize, logic overlay,
	                                logic alt, cpuAddrT addr, logic [2:0] strobes);
		rowT r;
		r.cfg     = '{turbo, romSize, ramSize};
		r.overlay = overlay;
		r.alt     = alt;
		r.addr    = addr | cpuAddrT'($urandom() & 32'hFFFF);	// random low bits
		{r.udsN, r.ldsN, r.rw} = strobes;
		r.dskInt  = memAddrT'($urandom());
		r.dskExt  = memAddrT'($urandom());
		return r;
	endfunction

	task automatic reportMismatch(string what, int got, int want);
		errors++;
		$display("FAIL t=%0t: %s got %h expected %h", $time, what, got, want);
	endtask

	task automatic resetDut();
		arstN = 1'b0;
		repeat (2) @(negedge clk8);
		arstN = 1'b1;
		sndRef    = SND_MAIN_BASE;
		accRef    = 0;
		vbLastRef = 1'b0;
		vidRef    = VID_BASE;
		pixRef    = 1'b0;
	endtask

	task automatic applyRow(rowT r);
		memConfig       = r.cfg;
		memoryOverlayOn = r.overlay;
		sndAlt          = r.alt;
		cpuAddr         = r.addr;
		cpuUdsN         = r.udsN;
		cpuLdsN         = r.ldsN;
		cpuRw           = r.rw;
		dskReadAddrInt  = r.dskInt;
		dskReadAddrExt  = r.dskExt;
	endtask

	// called at a falling edge with inputs in place, returns at the next one
	task automatic checkClock();
		busSlotT    slot;
		selectT     sel;
		memAddrT    want;
		logic [2:0] oeWant;	// romOeN, ramOeN, ramWeN
		logic [4:0] vidWant;	// hsync, vsync, hblankN, vblankN, loadPixels
		logic       live;
		int         x;
		int         y;
		#1;
		slot = slotRef(n, memConfig.turbo);
		sel = decodeRef(cpuAddr, memoryOverlayOn);
		x = n % lineClocks;	// beam position after n edges
		y = (n / lineClocks) % frameLines;
		live = n > 0;
		grantCount += busSlot.cpuGrant;
		if (busSlot !== slot)
			reportMismatch("bus slot", busSlot, slot);
		vidWant = {live && x >= lineClocks - hsyncClocks, live && y >= frameLines - vsyncLines,
		           live && x < activeClocks, vblankRef(n), pixRef};
		if ({hsync, vsync, hblankN, vblankN, loadPixels} !== vidWant)
			reportMismatch("video timing", {hsync, vsync, hblankN, vblankN, loadPixels}, vidWant);
		if ({scsiSel, sccSel, iwmSel, viaSel} !== {sel.scsi, sel.scc, sel.iwm, sel.via})
			reportMismatch("peripheral selects", {scsiSel, sccSel, iwmSel, viaSel}, sel);
		if ({memoryUdsN, memoryLdsN} !== (slot.cpuGrant ? {cpuUdsN, cpuLdsN} : 2'b00))
			reportMismatch("byte strobes", {memoryUdsN, memoryLdsN}, {cpuUdsN, cpuLdsN});
		if (!romOeN && !ramWeN)
			reportMismatch("rom read during ram write", romOeN, 1);
		if (slot.cpuGrant) begin
			want = sel.ram ? ramFold(cpuAddr[21:0], memConfig.ramSize) :
			       sel.rom ? romFold(cpuAddr[21:0], memConfig.romSize) : cpuAddr[21:0];
			if (memoryAddr !== want)
				reportMismatch("cpu memory address", memoryAddr, want);
			oeWant = {!(sel.rom && cpuRw), !(sel.ram && cpuRw), !(sel.ram && !cpuRw)};
		end else begin
			// disk reads open the rom, video and sound read ram, nobody writes
			oeWant = {!(slot.dskIntAck || slot.dskExtAck),
			          !((slot.videoGrant && vidWant[2]) || slot.sndAck), 1'b1};
		end
		if ({romOeN, ramOeN, ramWeN} !== oeWant)
			reportMismatch("oe/we", {romOeN, ramOeN, ramWeN}, oeWant);
		if (slot.videoGrant) begin
			want = ramFold(vidRef, memConfig.ramSize);
			if (memoryAddr !== want)
				reportMismatch("video address", memoryAddr, want);
		end
		if (slot.dskIntAck || slot.dskExtAck) begin
			want = slot.dskIntAck ? dskReadAddrInt + DSK_INT_BASE : dskReadAddrExt + DSK_EXT_BASE;
			if (memoryAddr !== want || romOeN !== 1'b0)
				reportMismatch("disk read address", memoryAddr, want);
		end
		if (slot.sndAck) begin
			want = ramFold(sndRef, memConfig.ramSize);
			if (memoryAddr !== want || loadSound !== 1'b1)
				reportMismatch("sound address", memoryAddr, want);
			// step the model the way the next edge will
			if (vbLastRef && !vblankRef(n)) begin
				sndRef = sndAlt ? SND_ALT_BASE : SND_MAIN_BASE;
				accRef = 0;
			end else if (accRef >= frameEvents - 1) begin
				accRef = accRef - frameEvents + stepEvents;
				sndRef = sndRef + 22'd2;
			end else begin
				accRef = accRef + stepEvents;
			end
			vbLastRef = vblankRef(n);
		end
		// frame buffer model, moved as the next edge will move it
		if (x == lineClocks - 1 && y == frameLines - 1)
			vidRef = VID_BASE;
		else if (pixRef)
			vidRef = vidRef + 22'd2;
		pixRef = slot.videoGrant && x < activeClocks && y < activeLines;
		@(negedge clk8);
	endtask

	task automatic logTestResult(string name, int errorsBefore);
		if (errors != errorsBefore)
			failedTests++;
		$display("%s: %s", name, errors == errorsBefore ? "ok" : "failed");
	endtask

	initial begin
		int errorsBefore;
		void'($urandom(92326));
		errors = 0;
		failedTests = 0;
		arstN = 1'b0;
		applyRow('0);
		// turbo, romSize, ramSize, overlay, alt, address, {udsN, ldsN, rw}
		rows[0]  = makeRow(0, 1, 3, 1, 0, 24'h0A0000, 3'b001);	// rom through overlay
		rows[1]  = makeRow(0, 0, 3, 1, 0, 24'h43C000, 3'b001);	// 64K rom
		rows[2]  = makeRow(0, 1, 0, 1, 1, 24'h6E0000, 3'b010);	// ram moved up, 128K
		rows[3]  = makeRow(1, 1, 1, 0, 1, 24'h3E0000, 3'b000);
		rows[4]  = makeRow(0, 1, 2, 0, 0, 24'h1F0000, 3'b100);
		rows[5]  = makeRow(1, 1, 3, 0, 0, 24'h3A0000, 3'b000);
		rows[6]  = makeRow(0, 0, 3, 0, 1, 24'h4F0000, 3'b001);
		rows[7]  = makeRow(0, 1, 3, 0, 0, 24'h5C0000, 3'b001);	// scsi
		rows[8]  = makeRow(1, 1, 3, 1, 0, 24'h9A0000, 3'b001);	// scc
		rows[9]  = makeRow(0, 1, 3, 0, 0, 24'hD40000, 3'b001);	// iwm
		rows[10] = makeRow(0, 1, 3, 1, 1, 24'hEC0000, 3'b000);	// via
		rows[11] = makeRow(0, 1, 3, 0, 0, 24'hF20000, 3'b001);	// unmapped
		for (int t = 0; t < 2; t++) begin
			memConfig = '{t[0], 1'b1, 2'd3};
			resetDut();
			errorsBefore = errors;
			grantCount = 0;
			repeat (64) checkClock();
			if (grantCount != (t ? 32 : 12))
				reportMismatch("cpu grants in 64 clocks", grantCount, t ? 32 : 12);
			logTestResult(t ? "slots turbo" : "slots normal", errorsBefore);
		end
		for (int r = 0; r < rowCount; r++) begin
			errorsBefore = errors;
			applyRow(rows[r]);
			repeat (rowClocks) checkClock();
			logTestResult($sformatf("row %0d addr %h", r, rows[r].addr), errorsBefore);
		end
		$display("tests %0d, failed %0d, errors %0d", rowCount + 2, failedTests, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

// ==== sim/addrController_props.sv ====
`timescale 1ns/1ps

module addrControllerProps import macBusPkg::*; (
	input logic    clk8,
	input logic    arstN,
	input busSlotT busSlot,	// from the slot sequencer
	input logic    romOeN,	// strobes from the address mapper
	input logic    ramWeN
);

	// one owner per bus clock
	assert property (@(posedge clk8) disable iff (!arstN)
		$onehot0({busSlot.videoGrant, busSlot.cpuGrant, busSlot.extraGrant}))
		else $error("two bus users granted in one clock");

	assert property (@(posedge clk8) disable iff (!arstN) !ramWeN |-> busSlot.cpuGrant)
		else $error("ram write outside a cpu slot");

	// both would drive the shared data bus
	assert property (@(posedge clk8) disable iff (!arstN) !(!romOeN && !ramWeN))
		else $error("rom read and ram write in the same clock");

endmodule

bind addrController addrControllerProps u_addrControllerProps (
	.clk8(clk8), .arstN(arstN), .busSlot(busSlot), .romOeN(romOeN), .ramWeN(ramWeN)
);

// ==== vlog.f ====
logic/macBusPkg.sv
logic/addrDecoder.sv
logic/busSlotSequencer.sv
logic/videoTimer.sv
logic/soundAddrGen.sv
logic/memAddrMapper.sv
logic/addrController.sv
sim/addrController_props.sv
sim/addrControllerTb.sv
